// File: project.f
hdl/regs_pkg.sv
hdl/video_pkg.sv
hdl/core_cfg_if.sv
hdl/host_regs.sv
hdl/video_config.sv
hdl/sd_router.sv
hdl/tape_control.sv
hdl/msx_glue_top.sv
bench/glue_checker.sv
bench/tb_msx_glue.sv

// File: Makefile
# Verilator build and run of the MSX board glue testbench

SRCS := $(wildcard hdl/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/tb_msx_glue: project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_msx_glue -o tb_msx_glue

run: obj_dir/tb_msx_glue
	@out="$$(./obj_dir/tb_msx_glue)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: bench/tb_msx_glue.sv
/*
 * Testbench for the MSX board glue top level.
 * Applies a table of APB accesses, pin changes and timed probes in a loop.
 * glue_checker compares all outputs, and a watchdog bounds the run
 * by the length of the table.
 */

`timescale 1ns/10ps

module tb_msx_glue import regs_pkg::*; ();

   localparam int ACT_HOLD   = 40;
   localparam int CLK_PERIOD = 40;

   // Row actions
   localparam int A_WRITE = 0;
   localparam int A_READ  = 1;
   localparam int A_PIN   = 2;
   localparam int A_WAIT  = 3;

   // Pins driven by A_PIN rows
   localparam int P_FSD     = 0;
   localparam int P_HDMI    = 1;
   localparam int P_MOUNT   = 2;
   localparam int P_SCK     = 3;
   localparam int P_MOSI    = 4;
   localparam int P_VMISO   = 5;
   localparam int P_DL      = 6;
   localparam int P_MOTOR   = 7;
   localparam int P_FILEBIT = 8;
   localparam int P_ADC     = 9;

   // Outputs probed at the end of A_WAIT rows
   localparam int C_NONE     = 0;
   localparam int C_LED_DISK = 1;
   localparam int C_LED_USER = 2;
   localparam int C_REWIND   = 3;
   localparam int C_PLAY     = 4;
   localparam int C_AUDIO    = 5;
   localparam int C_CROP     = 6;

   typedef struct packed {
      logic [7:0]  act;
      logic [7:0]  code;
      logic [31:0] value;
      logic [31:0] exp_val;
   } row_t;

   logic        clock_bus = 1'b0;
   logic        rst_n;
   logic [3:0]  paddr;
   logic        psel, penable, pwrite;
   logic [31:0] pwdata, prdata, img_size;
   logic [11:0] hdmi_width, hdmi_height, arx, ary, crop_size;
   logic        forced_scandoubler, hq2x, scandoubler;
   logic [1:0]  vga_sl, led_disk;
   logic [2:0]  scale_mode;
   logic        img_mount, spi_sck, spi_mosi, sd_miso, vsd_miso;
   logic        spi_miso, sd_sck, sd_mosi, sd_cs, vsd_ss, led_user;
   logic [5:0]  ioctl_index;
   logic        ioctl_download, cas_motor, cas_file_bit, tape_adc, tape_adc_act;
   logic        tape_play, tape_rewind, cas_audio_in, core_reset;

   row_t        rows[$];
   int          n_rows = 0;
   logic [31:0] seed = 32'h4bda_ad5f;
   string       probe_names [0:6] = '{"none", "led_disk[0]", "led_user",
                                      "tape_rewind", "tape_play", "cas_audio_in",
                                      "crop_size"};

   msx_glue_top #(.ACT_HOLD(ACT_HOLD)) uut (.*);

   glue_checker chk (.*);

   always #(CLK_PERIOD / 2) clock_bus = ~clock_bus;

   function automatic logic [31:0] next_random();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic void add_row(input int act, input int code,
                                   input logic [31:0] value, input logic [31:0] exp_val);
      rows.push_back({8'(act), 8'(code), value, exp_val});
   endfunction

   function automatic logic [31:0] probe(input int code);
      case (code)
         C_LED_DISK: return {31'd0, led_disk[0]};
         C_LED_USER: return {31'd0, led_user};
         C_REWIND:   return {31'd0, tape_rewind};
         C_PLAY:     return {31'd0, tape_play};
         C_AUDIO:    return {31'd0, cas_audio_in};
         C_CROP:     return {20'd0, crop_size};
         default:    return 32'd0;
      endcase
   endfunction

   // ======================================================================
   // Stimulus table
   // ======================================================================
   function automatic void build_table();
      logic [31:0] v;
      // Read-back, read-only STATUS, unmapped hole at 0x6
      add_row(A_WRITE, REG_CTRL, 32'h3, 0);
      add_row(A_READ, REG_CTRL, 0, 32'h1);
      add_row(A_WRITE, REG_CTRL, 32'h0, 0);
      add_row(A_READ, REG_CTRL, 0, 32'h0);
      add_row(A_WRITE, REG_TAPE, 32'hffff_ffff, 0);
      add_row(A_READ, REG_TAPE, 0, 32'h1);
      add_row(A_WRITE, REG_TAPE, 32'h0, 0);
      add_row(A_WRITE, REG_STATUS, 32'hffff_ffff, 0);
      add_row(A_READ, REG_STATUS, 0, 32'h0);
      add_row(A_WRITE, 4'h6, 32'hffff_ffff, 0);
      add_row(A_READ, 4'h6, 0, 32'h0);
      // Crop follows a 1080p panel with CRT50 and no forced doubler
      add_row(A_PIN, P_HDMI, 1, 0);
      add_row(A_WRITE, REG_VIDEO, 32'h0c, 0);
      add_row(A_WAIT, C_CROP, 1, 216);
      add_row(A_PIN, P_FSD, 1, 0);
      add_row(A_WAIT, C_CROP, 1, 0);
      add_row(A_PIN, P_FSD, 0, 0);
      add_row(A_WAIT, C_CROP, 1, 216);
      add_row(A_PIN, P_HDMI, 0, 0);
      add_row(A_WAIT, C_CROP, 1, 0);
      for (int i = 0; i < 6; i++) begin
         v = next_random();
         add_row(A_WRITE, REG_VIDEO, v, 0);
         add_row(A_READ, REG_VIDEO, 0, v & 32'hff);
         add_row(A_PIN, P_FSD, 1, 0);
         add_row(A_WAIT, C_NONE, 1, 0);
         add_row(A_PIN, P_FSD, 0, 0);
         add_row(A_PIN, P_HDMI, i % 2, 0);
         add_row(A_WAIT, C_NONE, 2, 0);
      end
      // Physical card activity, then a virtual image
      add_row(A_PIN, P_MOSI, 1, 0);
      add_row(A_WAIT, C_LED_DISK, 2, 1);
      add_row(A_WAIT, C_LED_DISK, ACT_HOLD + 4, 0);
      add_row(A_PIN, P_MOUNT, next_random() | 32'h1, 0);
      add_row(A_WAIT, C_NONE, 1, 0);
      add_row(A_READ, REG_STATUS, 0, 32'h1);
      add_row(A_PIN, P_SCK, 1, 0);
      add_row(A_PIN, P_VMISO, 0, 0);
      add_row(A_WAIT, C_LED_USER, ACT_HOLD + 4, 0);
      add_row(A_PIN, P_MOSI, 0, 0);
      add_row(A_WAIT, C_LED_USER, 2, 1);
      add_row(A_WAIT, C_LED_USER, ACT_HOLD + 4, 0);
      add_row(A_PIN, P_MOUNT, 0, 0);
      add_row(A_READ, REG_STATUS, 0, 32'h0);
      add_row(A_PIN, P_SCK, 0, 0);
      // Cassette load, play, rewind trigger and audio source
      add_row(A_PIN, P_DL, 32'h106, 0);
      add_row(A_WAIT, C_REWIND, 1, 0);
      add_row(A_PIN, P_DL, 32'h000, 0);
      add_row(A_PIN, P_DL, 32'h100 | CAS_INDEX, 0);
      add_row(A_WAIT, C_REWIND, 1, 1);
      add_row(A_PIN, P_DL, CAS_INDEX, 0);
      add_row(A_WAIT, C_REWIND, 1, 0);
      add_row(A_WAIT, C_PLAY, 0, 1);
      add_row(A_PIN, P_MOTOR, 1, 0);
      add_row(A_WAIT, C_PLAY, 0, 0);
      add_row(A_PIN, P_MOTOR, 0, 0);
      add_row(A_READ, REG_STATUS, 0, 32'h4);
      add_row(A_WRITE, REG_CTRL, 32'h2, 0);
      add_row(A_WAIT, C_REWIND, 0, 1);
      add_row(A_WAIT, C_REWIND, 1, 0);
      add_row(A_PIN, P_FILEBIT, 1, 0);
      add_row(A_WAIT, C_AUDIO, 0, 1);
      add_row(A_WRITE, REG_TAPE, 32'h1, 0);
      add_row(A_WAIT, C_AUDIO, 0, 0);
      add_row(A_PIN, P_ADC, 3, 0);
      add_row(A_WAIT, C_AUDIO, 0, 1);
      add_row(A_PIN, P_ADC, 1, 0);
      add_row(A_WAIT, C_AUDIO, 0, 0);
      add_row(A_WRITE, REG_TAPE, 32'h0, 0);
      add_row(A_WAIT, C_AUDIO, 0, 1);
   endfunction

   // Setup cycle, access cycle, read data taken mid access cycle
   task automatic apb_transfer(input logic wr, input logic [3:0] addr,
                               input logic [31:0] data, output logic [31:0] rdata);
      @(posedge clock_bus);
      #2;
      psel   = 1'b1;
      pwrite = wr;
      paddr  = addr;
      pwdata = data;
      @(posedge clock_bus);
      #2;
      penable = 1'b1;
      @(negedge clock_bus);
      rdata = prdata;
      @(posedge clock_bus);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic set_pin(input int code, input logic [31:0] value);
      @(posedge clock_bus);
      #2;
      case (code)
         P_FSD: forced_scandoubler = value[0];
         P_HDMI: begin
            hdmi_width  = value[0] ? 12'd1920 : 12'd1280;
            hdmi_height = value[0] ? 12'd1080 : 12'd720;
         end
         P_MOUNT: begin
            img_size  = value;
            img_mount = 1'b1;
         end
         P_SCK:     spi_sck = value[0];
         P_MOSI:    spi_mosi = value[0];
         P_VMISO:   vsd_miso = value[0];
         P_DL: begin
            ioctl_download = value[8];
            ioctl_index    = value[5:0];
         end
         P_MOTOR:   cas_motor = value[0];
         P_FILEBIT: cas_file_bit = value[0];
         P_ADC: begin
            tape_adc     = value[0];
            tape_adc_act = value[1];
         end
         default: ;
      endcase
      // Mount is a single-cycle strobe
      if (code == P_MOUNT) begin
         @(posedge clock_bus);
         #2;
         img_mount = 1'b0;
      end
   endtask

   // ======================================================================
   // Main sequence
   // ======================================================================
   initial begin
      logic [31:0] rdata;
      row_t        r;
      rst_n              = 1'b0;
      paddr              = 4'h0;
      psel               = 1'b0;
      penable            = 1'b0;
      pwrite             = 1'b0;
      pwdata             = 32'h0;
      hdmi_width         = 12'd1280;
      hdmi_height        = 12'd720;
      forced_scandoubler = 1'b0;
      img_mount          = 1'b0;
      img_size           = 32'h0;
      spi_sck            = 1'b0;
      spi_mosi           = 1'b0;
      sd_miso            = 1'b0;
      vsd_miso           = 1'b1;
      ioctl_download     = 1'b0;
      ioctl_index        = 6'd0;
      cas_motor          = 1'b0;
      cas_file_bit       = 1'b0;
      tape_adc           = 1'b0;
      tape_adc_act       = 1'b0;
      build_table();
      n_rows = rows.size();
      repeat (4) @(posedge clock_bus);
      #2;
      rst_n = 1'b1;
      for (int i = 0; i < n_rows; i++) begin
         r = rows[i];
         case (r.act)
            A_WRITE: apb_transfer(1'b1, r.code[3:0], r.value, rdata);
            A_READ: begin
               apb_transfer(1'b0, r.code[3:0], 32'h0, rdata);
               chk.check_value("prdata", rdata, r.exp_val);
            end
            A_PIN: set_pin(r.code, r.value);
            default: begin
               repeat (r.value) @(posedge clock_bus);
               @(negedge clock_bus);
               if (r.code != C_NONE)
                  chk.check_value(probe_names[r.code], probe(r.code), r.exp_val);
            end
         endcase
      end
      @(posedge clock_bus);
      $display("Rows: %0d  checks: %0d  errors: %0d", n_rows, chk.checks, chk.errors);
      if (chk.errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // Each row gets a generous 60 cycles
   initial begin
      wait (n_rows > 0);
      repeat (n_rows * 60) @(posedge clock_bus);
      $display("Watchdog expired before the stimulus table finished");
      $display("Test FAILED");
      $finish;
   end

endmodule

// File: bench/glue_checker.sv
/*
 * Checker for the MSX board glue testbench.
 * Follows APB writes, mounts and downloads to keep its own view of the
 * options and status. It compares the DUT outputs at every falling edge
 * and counts checks and errors. The testbench calls check_value for its
 * own table probes.
 */

`timescale 1ns/10ps

module glue_checker import regs_pkg::*, video_pkg::*; (
   input logic        clock_bus,
   input logic        rst_n,
   input logic [3:0]  paddr,
   input logic        psel, penable, pwrite,
   input logic [31:0] pwdata,
   input logic [11:0] hdmi_width, hdmi_height, arx, ary, crop_size,
   input logic        forced_scandoubler, hq2x, scandoubler,
   input logic [1:0]  vga_sl, led_disk,
   input logic [2:0]  scale_mode,
   input logic [31:0] img_size,
   input logic        img_mount, spi_sck, spi_mosi, sd_miso, vsd_miso,
   input logic        spi_miso, sd_sck, sd_mosi, sd_cs, vsd_ss, led_user,
   input logic [5:0]  ioctl_index,
   input logic        ioctl_download, cas_motor, cas_file_bit, tape_adc, tape_adc_act,
   input logic        tape_play, tape_rewind, cas_audio_in, core_reset
);

   int errors = 0;
   int checks = 0;

   // Expected register contents and status
   logic        core_m, src_m, rew_m, vsel_m, wr;
   logic [1:0]  aspect_m, state_m;
   logic [2:0]  fx_m, scale_m, sl_m;
   logic [11:0] crop_m;

   assign wr   = psel && penable && pwrite;
   assign sl_m = (fx_m != 3'd0) ? fx_m - 3'd1 : 3'd0;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp_val);
      checks++;
      if (got !== exp_val) begin
         errors++;
         $display("ERR %0d ns %s: got %0h, expected %0h", $time, name, got, exp_val);
      end
   endtask

   // ======================================================================
   // Reference state, updated on the same edges as the DUT
   // ======================================================================
   always @(posedge clock_bus) begin
      if (!rst_n) begin
         core_m   <= 1'b0;
         src_m    <= 1'b0;
         rew_m    <= 1'b0;
         vsel_m   <= 1'b0;
         aspect_m <= 2'd0;
         fx_m     <= 3'd0;
         scale_m  <= 3'd0;
         state_m  <= 2'd0;
         crop_m   <= 12'd0;
      end else begin
         rew_m <= wr && (paddr == REG_CTRL) && pwdata[1];
         if (wr && (paddr == REG_CTRL))
            core_m <= pwdata[0];
         if (wr && (paddr == REG_VIDEO)) begin
            aspect_m <= pwdata[1:0];
            fx_m     <= pwdata[4:2];
            scale_m  <= pwdata[7:5];
         end
         if (wr && (paddr == REG_TAPE))
            src_m <= pwdata[0];
         if (img_mount)
            vsel_m <= (img_size != 32'd0);
         // Ready holds until reset
         if ((state_m == 2'd0) && ioctl_download && (ioctl_index == CAS_INDEX))
            state_m <= 2'd1;
         else if ((state_m == 2'd1) && !ioctl_download)
            state_m <= 2'd2;
         crop_m <= ((hdmi_width == 12'd1920) && (hdmi_height == 12'd1080) &&
                    !forced_scandoubler && (fx_m != 3'd0)) ? 12'd216 : 12'd0;
      end
   end

   // ======================================================================
   // Output comparison at the falling edge
   // ======================================================================
   always @(negedge clock_bus) begin
      if (rst_n) begin
         check_value("vga_sl", vga_sl, sl_m[1:0]);
         check_value("hq2x", hq2x, fx_m == 3'd1);
         check_value("scandoubler", scandoubler, (fx_m != 3'd0) || forced_scandoubler);
         check_value("arx", arx, (aspect_m == 2'd0) ? 12'd4 : 12'(aspect_m - 2'd1));
         check_value("ary", ary, (aspect_m == 2'd0) ? 12'd3 : 12'd0);
         check_value("scale_mode", scale_mode, scale_m);
         check_value("crop_size", crop_size, crop_m);
         check_value("sd_cs", sd_cs, vsel_m);
         check_value("vsd_ss", vsd_ss, !vsel_m);
         check_value("sd_sck", sd_sck, spi_sck && !vsel_m);
         check_value("sd_mosi", sd_mosi, spi_mosi && !vsel_m);
         check_value("spi_miso", spi_miso, vsel_m ? vsd_miso : sd_miso);
         check_value("led_disk[1]", led_disk[1], 1'b1);
         // Only the LED of the selected card may light
         if (vsel_m)
            check_value("led_disk[0]", led_disk[0], 1'b0);
         else
            check_value("led_user", led_user, 1'b0);
         check_value("tape_play", tape_play, (state_m == 2'd2) && !cas_motor);
         check_value("tape_rewind", tape_rewind, rew_m || (state_m == 2'd1) || core_m);
         check_value("cas_audio_in", cas_audio_in,
                     src_m ? (tape_adc && tape_adc_act) : cas_file_bit);
         check_value("core_reset", core_reset, core_m);
      end
   end

endmodule

// File: hdl/msx_glue_top.sv
/*
 * Board glue top level for the MSX core.
 * Host options arrive over APB and are decoded into video, SD and
 * tape controls. ACT_HOLD sets the LED activity hold in clock cycles.
 */

`timescale 1ns/10ps

module msx_glue_top import regs_pkg::*, video_pkg::*; #(
   parameter int ACT_HOLD = 1_000_000
) (
   input  logic              clock_bus,
   input  logic              rst_n,
   // APB slave
   input  logic [ADDR_W-1:0] paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   // Video
   input  logic [HDMI_W-1:0] hdmi_width,
   input  logic [HDMI_W-1:0] hdmi_height,
   input  logic              forced_scandoubler,
   output logic [1:0]        vga_sl,
   output logic              hq2x,
   output logic              scandoubler,
   output logic [ARC_W-1:0]  arx,
   output logic [ARC_W-1:0]  ary,
   output logic [ARC_W-1:0]  crop_size,
   output logic [2:0]        scale_mode,
   // SD card
   input  logic              img_mount,
   input  logic [31:0]       img_size,
   input  logic              spi_sck,
   input  logic              spi_mosi,
   input  logic              sd_miso,
   input  logic              vsd_miso,
   output logic              spi_miso,
   output logic              sd_sck,
   output logic              sd_mosi,
   output logic              sd_cs,
   output logic              vsd_ss,
   output logic              led_user,
   output logic [1:0]        led_disk,
   // Cassette
   input  logic              ioctl_download,
   input  logic [5:0]        ioctl_index,
   input  logic              cas_motor,
   input  logic              cas_file_bit,
   input  logic              tape_adc,
   input  logic              tape_adc_act,
   output logic              tape_play,
   output logic              tape_rewind,
   output logic              cas_audio_in,
   // Core
   output logic              core_reset
);

   core_cfg_if cfg_bus ();

   assign core_reset = cfg_bus.core_reset;

   // =====================================================================
   // Blocks
   // =====================================================================
   host_regs u_regs (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .cfg       (cfg_bus.regs_mp)
   );

   video_config u_video (
      .clock_bus          (clock_bus),
      .rst_n              (rst_n),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .forced_scandoubler (forced_scandoubler),
      .cfg                (cfg_bus.video_mp),
      .vga_sl             (vga_sl),
      .hq2x               (hq2x),
      .scandoubler        (scandoubler),
      .arx                (arx),
      .ary                (ary),
      .crop_size          (crop_size),
      .scale_mode         (scale_mode)
   );

   sd_router #(
      .ACT_HOLD (ACT_HOLD)
   ) u_sd (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .img_mount (img_mount),
      .img_size  (img_size),
      .spi_sck   (spi_sck),
      .spi_mosi  (spi_mosi),
      .sd_miso   (sd_miso),
      .vsd_miso  (vsd_miso),
      .spi_miso  (spi_miso),
      .sd_sck    (sd_sck),
      .sd_mosi   (sd_mosi),
      .sd_cs     (sd_cs),
      .vsd_ss    (vsd_ss),
      .led_user  (led_user),
      .led_disk  (led_disk),
      .cfg       (cfg_bus.sd_mp)
   );

   tape_control u_tape (
      .clock_bus      (clock_bus),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .cas_motor      (cas_motor),
      .cas_file_bit   (cas_file_bit),
      .tape_adc       (tape_adc),
      .tape_adc_act   (tape_adc_act),
      .cfg            (cfg_bus.tape_mp),
      .tape_play      (tape_play),
      .tape_rewind    (tape_rewind),
      .cas_audio_in   (cas_audio_in)
   );

endmodule

// File: hdl/tape_control.sv
/*
 * Cassette control.
 * Follows the download of a cassette image, derives play and rewind
 * for the tape player, and picks the tape bit from the file player
 * or from the ADC comparator.
 */

`timescale 1ns/10ps

module tape_control import regs_pkg::*; (
   input  logic        clock_bus,
   input  logic        rst_n,
   input  logic        ioctl_download,
   input  logic [5:0]  ioctl_index,
   input  logic        cas_motor,
   input  logic        cas_file_bit,
   input  logic        tape_adc,
   input  logic        tape_adc_act,
   core_cfg_if.tape_mp cfg,
   output logic        tape_play,
   output logic        tape_rewind,
   output logic        cas_audio_in
);

   tape_state_t state;
   logic        cas_dl;

   assign cas_dl = ioctl_download && (ioctl_index == CAS_INDEX);

   // =====================================================================
   // Load FSM
   // =====================================================================
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         state <= TAPE_EMPTY;
      end else begin
         case (state)
            TAPE_EMPTY:   if (cas_dl) state <= TAPE_LOADING;
            TAPE_LOADING: if (!ioctl_download) state <= TAPE_READY;
            TAPE_READY:   state <= TAPE_READY;
            default:      state <= TAPE_EMPTY;
         endcase
      end
   end

   assign cfg.tape_state = state;

   // Player runs only with a loaded file and the motor relay off
   assign tape_play   = (state == TAPE_READY) && !cas_motor;
   assign tape_rewind = cfg.rewind_pulse || (state == TAPE_LOADING) || cfg.core_reset;

   assign cas_audio_in = (cfg.tape_src == TAPE_FILE) ? cas_file_bit
                                                     : (tape_adc & tape_adc_act);

   // Player never runs against the motor relay
   a_play_motor: assert property (@(posedge clock_bus) disable iff (!rst_n)
      !(tape_play && cas_motor));

endmodule

// File: hdl/sd_router.sv
/*
 * SD card routing between the physical slot and a mounted image.
 * A mount with a nonzero image size selects the virtual card.
 * Toggles on MOSI or MISO restart a hold timer that lights the
 * user LED for the virtual card and the disk LED for the physical one.
 */

`timescale 1ns/10ps

module sd_router #(
   parameter int ACT_HOLD = 1_000_000
) (
   input  logic        clock_bus,
   input  logic        rst_n,
   input  logic        img_mount,
   input  logic [31:0] img_size,
   input  logic        spi_sck,
   input  logic        spi_mosi,
   input  logic        sd_miso,
   input  logic        vsd_miso,
   output logic        spi_miso,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        sd_cs,
   output logic        vsd_ss,
   output logic        led_user,
   output logic [1:0]  led_disk,
   core_cfg_if.sd_mp   cfg
);

   localparam int              CNT_W    = $clog2(ACT_HOLD + 1);
   localparam logic [CNT_W-1:0] HOLD_CNT = CNT_W'(ACT_HOLD);

   logic             vsel;
   logic             old_mosi;
   logic             old_miso;
   logic             act;
   logic [CNT_W-1:0] timer;

   // =====================================================================
   // Card select
   // =====================================================================
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         vsel <= 1'b0;
      end else if (img_mount) begin
         vsel <= (img_size != '0);
      end
   end

   assign cfg.sd_vsel = vsel;

   // Physical slot is parked while the image is in use
   assign sd_cs    = vsel;
   assign vsd_ss   = ~vsel;
   assign sd_sck   = spi_sck & ~vsel;
   assign sd_mosi  = spi_mosi & ~vsel;
   assign spi_miso = vsel ? vsd_miso : sd_miso;

   // =====================================================================
   // Activity timer
   // =====================================================================
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         old_mosi <= 1'b0;
         old_miso <= 1'b0;
         act      <= 1'b0;
         timer    <= HOLD_CNT;
      end else begin
         old_mosi <= spi_mosi;
         old_miso <= spi_miso;
         act      <= 1'b0;
         if (timer < HOLD_CNT) begin
            timer <= timer + 1'b1;
            act   <= 1'b1;
         end
         // Any edge on the data lines restarts the hold
         if ((old_mosi ^ spi_mosi) || (old_miso ^ spi_miso))
            timer <= '0;
      end
   end

   assign led_user = vsel & act;
   assign led_disk = {1'b1, ~vsel & act};

   // Physical clock stays parked while the image is selected
   a_vsel_park: assert property (@(posedge clock_bus) disable iff (!rst_n)
      vsel |-> !sd_sck);

endmodule

// File: hdl/video_config.sv
/*
 * Video option decoder.
 * Turns the host fx, aspect and scale fields plus the HDMI output
 * size into scanline, scandoubler and scaler settings.
 * All outputs are combinational except the registered crop size.
 */

`timescale 1ns/10ps

module video_config import video_pkg::*; (
   input  logic              clock_bus,
   input  logic              rst_n,
   input  logic [HDMI_W-1:0] hdmi_width,
   input  logic [HDMI_W-1:0] hdmi_height,
   input  logic              forced_scandoubler,
   core_cfg_if.video_mp      cfg,
   output logic [1:0]        vga_sl,
   output logic              hq2x,
   output logic              scandoubler,
   output logic [ARC_W-1:0]  arx,
   output logic [ARC_W-1:0]  ary,
   output logic [ARC_W-1:0]  crop_size,
   output logic [2:0]        scale_mode
);

   logic [2:0] sl_level;
   logic [1:0] ar_idx;
   logic       fx_on;
   logic       crop_en;

   assign fx_on = (cfg.fx != FX_NONE);

   // Scanline level, CRT25 is level 1 and so on
   assign sl_level    = fx_on ? (3'(cfg.fx) - 3'd1) : 3'd0;
   assign vga_sl      = sl_level[1:0];
   assign hq2x        = (cfg.fx == FX_HQ2X);
   assign scandoubler = fx_on || forced_scandoubler;

   // =====================================================================
   // Aspect ratio
   // =====================================================================
   // Custom settings pass an index to the scaler rather than a ratio
   assign ar_idx = 2'(cfg.aspect) - 2'd1;
   assign arx    = (cfg.aspect == AR_ORIGINAL) ? 12'd4 : {{(ARC_W-2){1'b0}}, ar_idx};
   assign ary    = (cfg.aspect == AR_ORIGINAL) ? 12'd3 : '0;

   assign scale_mode = cfg.int_scale;

   // 216p crop only when doubling onto a true 1080p panel
   assign crop_en = (hdmi_width == FULLHD_W) && (hdmi_height == FULLHD_H) &&
                    !forced_scandoubler && fx_on;

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         crop_size <= '0;
      end else begin
         crop_size <= crop_en ? CROP_LINES : '0;
      end
   end

endmodule

// File: hdl/host_regs.sv
/*
 * APB slave holding the host-visible option registers.
 * Zero wait states, no ready or error response. Writes land on the
 * edge that ends the access cycle; unmapped reads return zero.
 * The CTRL rewind bit is a trigger and reads back as 0.
 */

`timescale 1ns/10ps

module host_regs import regs_pkg::*, video_pkg::*; (
   input  logic              clock_bus,
   input  logic              rst_n,
   input  logic [ADDR_W-1:0] paddr,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   core_cfg_if.regs_mp       cfg
);

   logic wr_en;

   assign wr_en = psel && penable && pwrite;

   // =====================================================================
   // Register writes
   // =====================================================================
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         cfg.core_reset   <= 1'b0;
         cfg.aspect       <= AR_ORIGINAL;
         cfg.fx           <= FX_NONE;
         cfg.int_scale    <= 3'd0;
         cfg.tape_src     <= TAPE_FILE;
         cfg.rewind_pulse <= 1'b0;
      end else begin
         // Trigger only lives for the cycle after the write
         cfg.rewind_pulse <= 1'b0;
         if (wr_en) begin
            case (paddr)
               REG_CTRL: begin
                  cfg.core_reset   <= pwdata[CTRL_RESET_BIT];
                  cfg.rewind_pulse <= pwdata[CTRL_REWIND_BIT];
               end
               REG_VIDEO: begin
                  cfg.aspect    <= aspect_t'(pwdata[VID_AR_LSB +: 2]);
                  cfg.fx        <= fx_t'(pwdata[VID_FX_LSB +: 3]);
                  cfg.int_scale <= pwdata[VID_SCALE_LSB +: 3];
               end
               REG_TAPE: begin
                  cfg.tape_src <= tape_src_t'(pwdata[TAPE_SRC_BIT]);
               end
               default: begin
                  // STATUS and holes take no writes
               end
            endcase
         end
      end
   end

   // =====================================================================
   // Read mux
   // =====================================================================
   always_comb begin
      prdata = '0;
      if (psel && !pwrite) begin
         case (paddr)
            REG_CTRL:   prdata[CTRL_RESET_BIT] = cfg.core_reset;
            REG_VIDEO: begin
               prdata[VID_AR_LSB +: 2]    = cfg.aspect;
               prdata[VID_FX_LSB +: 3]    = cfg.fx;
               prdata[VID_SCALE_LSB +: 3] = cfg.int_scale;
            end
            REG_TAPE:   prdata[TAPE_SRC_BIT] = cfg.tape_src;
            REG_STATUS: begin
               prdata[STAT_VSEL_BIT]      = cfg.sd_vsel;
               prdata[STAT_TAPE_LSB +: 2] = cfg.tape_state;
            end
            default:    prdata = '0;
         endcase
      end
   end

   // Access phase only ever follows a selected setup phase
   a_penable_psel: assert property (@(posedge clock_bus) disable iff (!rst_n)
      penable |-> psel);

endmodule

// File: hdl/core_cfg_if.sv
/*
 * Decoded core options and status inside the glue layer.
 * The register block drives the options, the video, tape and SD
 * blocks take what they need through their own modport, and status
 * flows back to the register block for read-back.
 */

`timescale 1ns/10ps

interface core_cfg_if import regs_pkg::*, video_pkg::*; ();

   // Host options
   logic        core_reset;
   aspect_t     aspect;
   fx_t         fx;
   logic [2:0]  int_scale;
   tape_src_t   tape_src;
   logic        rewind_pulse;

   // Status from the function blocks
   tape_state_t tape_state;
   logic        sd_vsel;

   modport regs_mp (
      output core_reset, aspect, fx, int_scale, tape_src, rewind_pulse,
      input  tape_state, sd_vsel
   );

   modport video_mp (
      input aspect, fx, int_scale
   );

   modport tape_mp (
      input  core_reset, tape_src, rewind_pulse,
      output tape_state
   );

   modport sd_mp (
      output sd_vsel
   );

endinterface

// File: hdl/video_pkg.sv
/*
 * Video option encodings and display constants.
 * Shared by the register block, the option decoder and the top level.
 */

package video_pkg;

   // Aspect ratio selection as written by the host
   typedef enum logic [1:0] {
      AR_ORIGINAL = 2'd0,
      AR_FULL     = 2'd1,
      AR_CUSTOM1  = 2'd2,
      AR_CUSTOM2  = 2'd3
   } aspect_t;

   // Scandoubler effect, CRT levels map to scanline strength
   typedef enum logic [2:0] {
      FX_NONE  = 3'd0,
      FX_HQ2X  = 3'd1,
      FX_CRT25 = 3'd2,
      FX_CRT50 = 3'd3,
      FX_CRT75 = 3'd4
   } fx_t;

   localparam int ARC_W  = 12;
   localparam int HDMI_W = 12;

   // 1080p output gets the 216-line crop
   localparam logic [ARC_W-1:0]  CROP_LINES = 12'd216;
   localparam logic [HDMI_W-1:0] FULLHD_W   = 12'd1920;
   localparam logic [HDMI_W-1:0] FULLHD_H   = 12'd1080;

endpackage

// File: hdl/regs_pkg.sv
/*
 * Host register map for the MSX board glue.
 * Addresses, bit positions of the register fields, and the
 * host-side enums shared by the register block and the tape logic.
 * Import into the modules and the interface that need them.
 */

package regs_pkg;

   // =====================================================================
   // APB geometry
   // =====================================================================
   localparam int ADDR_W = 4;
   localparam int DATA_W = 32;

   // Register addresses
   localparam logic [ADDR_W-1:0] REG_CTRL   = 4'h0;
   localparam logic [ADDR_W-1:0] REG_VIDEO  = 4'h4;
   localparam logic [ADDR_W-1:0] REG_TAPE   = 4'h8;
   localparam logic [ADDR_W-1:0] REG_STATUS = 4'hC;

   // =====================================================================
   // Field positions
   // =====================================================================
   localparam int CTRL_RESET_BIT  = 0;
   localparam int CTRL_REWIND_BIT = 1;
   localparam int VID_AR_LSB      = 0;
   localparam int VID_FX_LSB      = 2;
   localparam int VID_SCALE_LSB   = 5;
   localparam int TAPE_SRC_BIT    = 0;
   localparam int STAT_VSEL_BIT   = 0;
   localparam int STAT_TAPE_LSB   = 1;

   // Download slot of a cassette image
   localparam logic [5:0] CAS_INDEX = 6'd5;

   typedef enum logic {
      TAPE_FILE = 1'b0,
      TAPE_ADC  = 1'b1
   } tape_src_t;

   typedef enum logic [1:0] {
      TAPE_EMPTY   = 2'd0,
      TAPE_LOADING = 2'd1,
      TAPE_READY   = 2'd2
   } tape_state_t;

endpackage
